//--- rtl/tusca_pkg.sv
/*
 * Measurement widths, temperature level enum,
 * and fan PWM and servo timing constants.
 */
package tusca_pkg;

  // Sensor frame layout.
  localparam int BYTE_W  = 8;
  localparam int FRAME_W = 5 * BYTE_W;

  // Temperature level, one step per threshold reached.
  typedef enum logic [2:0] {
    NIVEL_0 = 3'd0,
    NIVEL_1 = 3'd1,
    NIVEL_2 = 3'd2,
    NIVEL_3 = 3'd3,
    NIVEL_4 = 3'd4
  } nivel_t;

  // Fan PWM, scaled down for simulation.
  localparam int PWM_PERIOD = 64;
  localparam int FAN_STEP   = 16;

  // Servo frame and pulse widths.
  localparam int SERVO_PERIOD = 256;
  localparam int SERVO_BASE   = 16;
  localparam int SERVO_STEP   = 8;

  // Counter widths.
  localparam int PWM_CNT_W   = $clog2(PWM_PERIOD);
  localparam int FAN_DUTY_W  = $clog2(PWM_PERIOD + 1);
  localparam int SERVO_CNT_W = $clog2(SERVO_PERIOD);
  localparam int SERVO_W     = $clog2(SERVO_PERIOD + 1);

endpackage

//--- rtl/tusca_regs_pkg.sv
/*
 * Register map of the threshold block: address width,
 * register addresses and reset threshold values.
 */
package tusca_regs_pkg;

  localparam int ADDR_W = 5;

  typedef enum logic [ADDR_W-1:0] {
    REG_LIM_TEMP1   = 5'h00,
    REG_LIM_TEMP2   = 5'h04,
    REG_LIM_TEMP3   = 5'h08,
    REG_LIM_TEMP4   = 5'h0C,
    REG_LIM_UMIDADE = 5'h10
  } reg_addr_t;

  // Temperature limits must stay strictly ascending.
  localparam int unsigned LIM_TEMP1_RST   = 20;
  localparam int unsigned LIM_TEMP2_RST   = 25;
  localparam int unsigned LIM_TEMP3_RST   = 30;
  localparam int unsigned LIM_TEMP4_RST   = 35;
  localparam int unsigned LIM_UMIDADE_RST = 70;

endpackage

//--- rtl/tusca_config_regs.sv
/*
 * APB slave for the temperature and humidity limits,
 * with the ascending-order check and sticky config error.
 */
`timescale 1ns/1ps

module tusca_config_regs
  import tusca_pkg::*, tusca_regs_pkg::*;
(
  input  logic              clock,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              erro_config,
  output logic [BYTE_W-1:0] lim_temp1,
  output logic [BYTE_W-1:0] lim_temp2,
  output logic [BYTE_W-1:0] lim_temp3,
  output logic [BYTE_W-1:0] lim_temp4,
  output logic [BYTE_W-1:0] lim_umidade
);

  logic [BYTE_W-1:0] wbyte;
  logic [BYTE_W-1:0] rbyte;
  logic              access;
  logic              mapped;
  logic              order_ok;
  logic              accept;

  assign wbyte  = pwdata[BYTE_W-1:0];
  assign access = psel && penable;
  assign pready = 1'b1; // No wait states.

  // Decode, readback and neighbour check.
  always_comb begin
    mapped   = 1'b1;
    order_ok = 1'b1;
    rbyte    = '0;
    case (reg_addr_t'(paddr))
      REG_LIM_TEMP1: begin
        rbyte    = lim_temp1;
        order_ok = wbyte < lim_temp2;
      end
      REG_LIM_TEMP2: begin
        rbyte    = lim_temp2;
        order_ok = (wbyte > lim_temp1) && (wbyte < lim_temp3);
      end
      REG_LIM_TEMP3: begin
        rbyte    = lim_temp3;
        order_ok = (wbyte > lim_temp2) && (wbyte < lim_temp4);
      end
      REG_LIM_TEMP4: begin
        rbyte    = lim_temp4;
        order_ok = wbyte > lim_temp3;
      end
      REG_LIM_UMIDADE: rbyte = lim_umidade;
      default:         mapped = 1'b0;
    endcase
  end

  assign prdata  = {{(32 - BYTE_W){1'b0}}, rbyte};
  assign pslverr = access && (!mapped || (pwrite && !order_ok));
  assign accept  = access && pwrite && mapped && order_ok;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      lim_temp1   <= BYTE_W'(LIM_TEMP1_RST);
      lim_temp2   <= BYTE_W'(LIM_TEMP2_RST);
      lim_temp3   <= BYTE_W'(LIM_TEMP3_RST);
      lim_temp4   <= BYTE_W'(LIM_TEMP4_RST);
      lim_umidade <= BYTE_W'(LIM_UMIDADE_RST);
      erro_config <= 1'b0;
    end else begin
      if (accept) begin
        case (reg_addr_t'(paddr))
          REG_LIM_TEMP1:   lim_temp1   <= wbyte;
          REG_LIM_TEMP2:   lim_temp2   <= wbyte;
          REG_LIM_TEMP3:   lim_temp3   <= wbyte;
          REG_LIM_TEMP4:   lim_temp4   <= wbyte;
          REG_LIM_UMIDADE: lim_umidade <= wbyte;
          default:         lim_umidade <= lim_umidade;
        endcase
      end
      if (pslverr && pwrite)
        erro_config <= 1'b1; // Held until a good write.
      else if (accept)
        erro_config <= 1'b0;
    end
  end

  a_slverr_in_access: assert property (
    @(posedge clock) disable iff (!rst_n) pslverr |-> psel && penable);

endmodule

//--- rtl/tusca_frame_check.sv
/*
 * Pipeline stage 1: splits the sensor frame, checks the
 * checksum and registers the integer measurement bytes.
 */
`timescale 1ns/1ps

module tusca_frame_check
  import tusca_pkg::*;
(
  input  logic               clock,
  input  logic               rst_n,
  input  logic               frame_valid,
  input  logic [FRAME_W-1:0] frame_data,
  output logic               meas_valid,
  output logic               erro_medida,
  output logic [BYTE_W-1:0]  temperatura,
  output logic [BYTE_W-1:0]  umidade
);

  logic [BYTE_W-1:0] umid_int;
  logic [BYTE_W-1:0] umid_dec;
  logic [BYTE_W-1:0] temp_int;
  logic [BYTE_W-1:0] temp_dec;
  logic [BYTE_W-1:0] checksum;
  logic [BYTE_W-1:0] soma;
  logic              soma_ok;

  // Humidity first, checksum in the last byte.
  assign {umid_int, umid_dec, temp_int, temp_dec, checksum} = frame_data;

  assign soma    = umid_int + umid_dec + temp_int + temp_dec; // Wraps to 8 bits.
  assign soma_ok = soma == checksum;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      meas_valid  <= 1'b0;
      erro_medida <= 1'b0;
    end else begin
      meas_valid  <= frame_valid && soma_ok;
      erro_medida <= frame_valid && !soma_ok;
    end
  end

  // Measurement bytes only move on a good frame.
  always_ff @(posedge clock) begin
    if (frame_valid && soma_ok) begin
      temperatura <= temp_int;
      umidade     <= umid_int;
    end
  end

  a_valid_xor_err: assert property (
    @(posedge clock) disable iff (!rst_n) !(meas_valid && erro_medida));

endmodule

//--- rtl/tusca_level_classifier.sv
/*
 * Pipeline stage 2: temperature level from four ascending
 * limits, and relay request from the humidity limit.
 */
`timescale 1ns/1ps

module tusca_level_classifier
  import tusca_pkg::*;
(
  input  logic              clock,
  input  logic              rst_n,
  input  logic              meas_valid,
  input  logic [BYTE_W-1:0] temperatura,
  input  logic [BYTE_W-1:0] umidade,
  input  logic [BYTE_W-1:0] lim_temp1,
  input  logic [BYTE_W-1:0] lim_temp2,
  input  logic [BYTE_W-1:0] lim_temp3,
  input  logic [BYTE_W-1:0] lim_temp4,
  input  logic [BYTE_W-1:0] lim_umidade,
  output logic              nivel_valid,
  output nivel_t            nivel,
  output logic              rele_req
);

  logic [3:0] atingido;
  logic [2:0] contagem;

  assign atingido[0] = temperatura >= lim_temp1;
  assign atingido[1] = temperatura >= lim_temp2;
  assign atingido[2] = temperatura >= lim_temp3;
  assign atingido[3] = temperatura >= lim_temp4;

  // Count of limits reached, not a priority encode.
  assign contagem = {2'b00, atingido[0]} + {2'b00, atingido[1]}
                  + {2'b00, atingido[2]} + {2'b00, atingido[3]};

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      nivel_valid <= 1'b0;
      nivel       <= NIVEL_0;
      rele_req    <= 1'b0;
    end else begin
      nivel_valid <= meas_valid;
      if (meas_valid) begin
        nivel    <= nivel_t'(contagem);
        rele_req <= umidade > lim_umidade; // Strictly above.
      end
    end
  end

  a_nivel_range: assert property (
    @(posedge clock) disable iff (!rst_n) nivel <= NIVEL_4);

endmodule

//--- rtl/tusca_actuator.sv
/*
 * Pipeline stage 3: relay register, fan PWM and servo pulse.
 * Fan and servo take a new level only at a period start.
 */
`timescale 1ns/1ps

module tusca_actuator
  import tusca_pkg::*;
(
  input  logic   clock,
  input  logic   rst_n,
  input  logic   nivel_valid,
  input  nivel_t nivel,
  input  logic   rele_req,
  output logic   rele,
  output logic   pwm_ventoinha,
  output logic   pwm_servo
);

  nivel_t                 nivel_atual;
  logic [PWM_CNT_W-1:0]   cnt_fan;
  logic [SERVO_CNT_W-1:0] cnt_servo;
  logic [FAN_DUTY_W-1:0]  duty_fan;
  logic [SERVO_W-1:0]     largura_servo;
  logic                   fim_fan;
  logic                   fim_servo;

  assign fim_fan   = cnt_fan == PWM_CNT_W'(PWM_PERIOD - 1);
  assign fim_servo = cnt_servo == SERVO_CNT_W'(SERVO_PERIOD - 1);

  // Pending level and relay.
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      nivel_atual <= NIVEL_0;
      rele        <= 1'b0;
    end else if (nivel_valid) begin
      nivel_atual <= nivel;
      rele        <= rele_req;
    end
  end

  // Fan period counter, duty loaded for the next period.
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      cnt_fan  <= '0;
      duty_fan <= '0;
    end else begin
      cnt_fan <= fim_fan ? '0 : cnt_fan + 1'b1;
      if (fim_fan)
        duty_fan <= FAN_DUTY_W'(nivel_atual) * FAN_DUTY_W'(FAN_STEP);
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      cnt_servo     <= '0;
      largura_servo <= SERVO_W'(SERVO_BASE);
    end else begin
      cnt_servo <= fim_servo ? '0 : cnt_servo + 1'b1;
      if (fim_servo)
        largura_servo <= SERVO_W'(SERVO_BASE)
                       + SERVO_W'(nivel_atual) * SERVO_W'(SERVO_STEP);
    end
  end

  assign pwm_ventoinha = {1'b0, cnt_fan} < duty_fan;
  assign pwm_servo     = {1'b0, cnt_servo} < largura_servo;

  a_servo_fits: assert property (
    @(posedge clock) disable iff (!rst_n) largura_servo <= SERVO_W'(SERVO_PERIOD));

endmodule

//--- rtl/tusca.sv
/*
 * Climate controller top: APB threshold registers and the
 * frame check, level and actuator pipeline.
 */
`timescale 1ns/1ps

module tusca
  import tusca_pkg::*, tusca_regs_pkg::*;
(
  input  logic               clock,
  input  logic               rst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [ADDR_W-1:0]  paddr,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  input  logic               frame_valid,
  input  logic [FRAME_W-1:0] frame_data,
  output logic               erro_medida,
  output logic               erro_config,
  output logic               nivel_valid,
  output nivel_t             nivel,
  output logic               rele,
  output logic               pwm_ventoinha,
  output logic               pwm_servo
);

  logic [BYTE_W-1:0] lim_temp1;
  logic [BYTE_W-1:0] lim_temp2;
  logic [BYTE_W-1:0] lim_temp3;
  logic [BYTE_W-1:0] lim_temp4;
  logic [BYTE_W-1:0] lim_umidade;
  logic              meas_valid;
  logic [BYTE_W-1:0] temperatura;
  logic [BYTE_W-1:0] umidade;
  logic              rele_req;

  tusca_config_regs config_regs (
    .clock(clock),
    .rst_n(rst_n),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .erro_config(erro_config),
    .lim_temp1(lim_temp1),
    .lim_temp2(lim_temp2),
    .lim_temp3(lim_temp3),
    .lim_temp4(lim_temp4),
    .lim_umidade(lim_umidade)
  );

  tusca_frame_check frame_check (
    .clock(clock),
    .rst_n(rst_n),
    .frame_valid(frame_valid),
    .frame_data(frame_data),
    .meas_valid(meas_valid),
    .erro_medida(erro_medida),
    .temperatura(temperatura),
    .umidade(umidade)
  );

  tusca_level_classifier classifier (
    .clock(clock),
    .rst_n(rst_n),
    .meas_valid(meas_valid),
    .temperatura(temperatura),
    .umidade(umidade),
    .lim_temp1(lim_temp1),
    .lim_temp2(lim_temp2),
    .lim_temp3(lim_temp3),
    .lim_temp4(lim_temp4),
    .lim_umidade(lim_umidade),
    .nivel_valid(nivel_valid),
    .nivel(nivel),
    .rele_req(rele_req)
  );

  tusca_actuator actuator (
    .clock(clock),
    .rst_n(rst_n),
    .nivel_valid(nivel_valid),
    .nivel(nivel),
    .rele_req(rele_req),
    .rele(rele),
    .pwm_ventoinha(pwm_ventoinha),
    .pwm_servo(pwm_servo)
  );

endmodule

//--- sim/tb_clock.sv
/*
 * Free-running testbench clock, 40 ns period.
 */
`timescale 1ns/1ps

module tb_clock (
  output logic clock
);

  localparam int HALF_PERIOD_NS = 20;

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD_NS clock = ~clock; // 25 MHz.
  end

endmodule

//--- sim/tusca_tb.sv
/*
 * Testbench for the climate controller: APB threshold access,
 * frame pipeline with reference model and queued compare,
 * relay timing and fan and servo duty counts.
 */
`timescale 1ns/1ps

module tusca_tb
  import tusca_pkg::*, tusca_regs_pkg::*;
();

  localparam int APB_ACCESSES   = 40;
  localparam int FRAMES         = 200;
  localparam int TEST_CYCLES    = 16 + APB_ACCESSES * 4 + FRAMES * 8 + 10 * SERVO_PERIOD;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic               clock;
  logic               rst_n;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [ADDR_W-1:0]  paddr;
  logic [31:0]        pwdata;
  logic [31:0]        prdata;
  logic               pready;
  logic               pslverr;
  logic               frame_valid;
  logic [FRAME_W-1:0] frame_data;
  logic               erro_medida;
  logic               erro_config;
  logic               nivel_valid;
  nivel_t             nivel;
  logic               rele;
  logic               pwm_ventoinha;
  logic               pwm_servo;

  integer            seed;
  int                cyc = 0;
  int                err_count = 0;
  logic [BYTE_W-1:0] lim_m [5];   // Model copy of the thresholds.
  logic              cfg_err_m = 1'b0;
  nivel_t            held_nivel = NIVEL_0;
  logic              held_rele = 1'b0;

  // Pending pipeline results, one entry per frame.
  int     due_q[$];
  bit     err_q[$];
  nivel_t nivel_q[$];
  bit     exp_rele_q[$];
  int     rele_due_q[$];
  bit     rele_val_q[$];

  tb_clock clk_gen (.clock(clock));

  tusca tusca_inst (
    .clock(clock),
    .rst_n(rst_n),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .frame_valid(frame_valid),
    .frame_data(frame_data),
    .erro_medida(erro_medida),
    .erro_config(erro_config),
    .nivel_valid(nivel_valid),
    .nivel(nivel),
    .rele(rele),
    .pwm_ventoinha(pwm_ventoinha),
    .pwm_servo(pwm_servo)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "%s", msg);
  endtask

  task automatic report_mismatch(input string name, input string exp_s, input string act_s);
    err_count++;
    fail_run($sformatf("MISMATCH %s: expected %s, actual %s", name, exp_s, act_s));
  endtask

  task automatic check_nivel(input string name, input nivel_t exp, input nivel_t act);
    if (act !== exp)
      report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      report_mismatch(name, $sformatf("0x%08h", exp), $sformatf("0x%08h", act));
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
      report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  function automatic logic [BYTE_W-1:0] calc_checksum(input logic [BYTE_W-1:0] a,
      input logic [BYTE_W-1:0] b, input logic [BYTE_W-1:0] c, input logic [BYTE_W-1:0] d);
    return a + b + c + d; // Low byte of the sum.
  endfunction

  function automatic nivel_t ref_nivel(input logic [BYTE_W-1:0] temp);
    int n;
    n = 0;
    for (int i = 0; i < 4; i++)
      if (lim_m[i] <= temp)
        n++;
    return nivel_t'(n);
  endfunction

  function automatic bit ref_rele(input logic [BYTE_W-1:0] umid);
    return umid > lim_m[4];
  endfunction

  function automatic int ref_fan_high(input int lvl);
    return lvl * FAN_STEP;
  endfunction

  function automatic int ref_servo_high(input int lvl);
    return SERVO_BASE + lvl * SERVO_STEP;
  endfunction

  function automatic int reg_index(input logic [ADDR_W-1:0] addr);
    case (addr)
      REG_LIM_TEMP1:   return 0;
      REG_LIM_TEMP2:   return 1;
      REG_LIM_TEMP3:   return 2;
      REG_LIM_TEMP4:   return 3;
      REG_LIM_UMIDADE: return 4;
      default:         return -1;
    endcase
  endfunction

  // Temperature limits must stay strictly ascending.
  function automatic bit write_allowed(input int idx, input logic [BYTE_W-1:0] val);
    if (idx < 0)
      return 1'b0;
    if (idx > 0 && idx < 4 && val <= lim_m[idx-1])
      return 1'b0;
    if (idx < 3 && val >= lim_m[idx+1])
      return 1'b0;
    return 1'b1;
  endfunction

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [BYTE_W-1:0] val,
      input string name);
    int idx;
    bit ok;
    idx = reg_index(addr);
    ok  = write_allowed(idx, val);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= {24'h0, val};
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);
    check_bit({name, " pslverr"}, !ok, pslverr);
    check_bit({name, " pready"}, 1'b1, pready);
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
    if (ok) begin
      lim_m[idx] = val;
      cfg_err_m  = 1'b0;
    end else begin
      cfg_err_m = 1'b1;
    end
    @(negedge clock);
    check_bit({name, " erro_config"}, cfg_err_m, erro_config);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, input string name);
    int          idx;
    logic [31:0] exp_data;
    idx      = reg_index(addr);
    exp_data = '0;
    if (idx >= 0)
      exp_data = {24'h0, lim_m[idx]};
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);
    check_word({name, " prdata"}, exp_data, prdata);
    check_bit({name, " pslverr"}, idx < 0, pslverr);
    check_bit({name, " erro_config"}, cfg_err_m, erro_config);
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_all(input string prefix);
    for (int i = 0; i < 5; i++)
      apb_read(ADDR_W'(i * 4), $sformatf("%s reg%0d", prefix, i));
  endtask

  task automatic drive_frame(input logic [BYTE_W-1:0] umid, input logic [BYTE_W-1:0] temp,
      input bit corrupt);
    logic [BYTE_W-1:0] umid_dec;
    logic [BYTE_W-1:0] temp_dec;
    logic [BYTE_W-1:0] cs;
    umid_dec = BYTE_W'($random(seed));
    temp_dec = BYTE_W'($random(seed));
    cs       = calc_checksum(umid, umid_dec, temp, temp_dec);
    if (corrupt)
      cs = cs ^ BYTE_W'(({$random(seed)} % 255) + 1); // Never a zero mask.
    @(posedge clock);
    frame_valid <= 1'b1;
    frame_data  <= {umid, umid_dec, temp, temp_dec, cs};
    due_q.push_back(cyc + 1 + (corrupt ? 1 : 2));
    err_q.push_back(corrupt);
    nivel_q.push_back(ref_nivel(temp));
    exp_rele_q.push_back(ref_rele(umid));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      frame_valid <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    idle_cycles(1);
    while (due_q.size() != 0 || rele_due_q.size() != 0)
      @(negedge clock);
    @(negedge clock);
  endtask

  always @(posedge clock) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES)
      fail_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  // Pipeline compare, sampled away from the active edge.
  always @(negedge clock) begin : compare
    bit     err;
    nivel_t lvl;
    bit     rl;
    bit     exp_err;
    bit     exp_valid;
    if (rst_n) begin
      if (rele_due_q.size() != 0 && rele_due_q[0] == cyc) begin
        void'(rele_due_q.pop_front());
        held_rele = rele_val_q.pop_front();
      end
      exp_err   = 1'b0;
      exp_valid = 1'b0;
      lvl       = NIVEL_0;
      rl        = 1'b0;
      // A good frame and the bad one behind it come out together.
      while (due_q.size() != 0 && due_q[0] <= cyc) begin
        void'(due_q.pop_front());
        err = err_q.pop_front();
        if (err) begin
          exp_err = 1'b1;
          void'(nivel_q.pop_front());
          void'(exp_rele_q.pop_front());
        end else begin
          exp_valid = 1'b1;
          lvl       = nivel_q.pop_front();
          rl        = exp_rele_q.pop_front();
        end
      end
      check_bit("erro_medida", exp_err, erro_medida);
      check_bit("nivel_valid", exp_valid, nivel_valid);
      if (exp_valid) begin
        check_nivel("level", lvl, nivel);
        held_nivel = lvl;
        rele_due_q.push_back(cyc + 1); // Relay follows one cycle later.
        rele_val_q.push_back(rl);
      end
      check_nivel("held level", held_nivel, nivel);
      check_bit("held rele", held_rele, rele);
    end
  end

  initial begin
    int                gap;
    bit                corrupt;
    int                fan_high;
    int                servo_high;
    logic [BYTE_W-1:0] temp;
    seed        = 32'h15451da5;
    rst_n       <= 1'b0;
    psel        <= 1'b0;
    penable     <= 1'b0;
    pwrite      <= 1'b0;
    paddr       <= '0;
    pwdata      <= '0;
    frame_valid <= 1'b0;
    frame_data  <= '0;
    lim_m[0] = BYTE_W'(LIM_TEMP1_RST);
    lim_m[1] = BYTE_W'(LIM_TEMP2_RST);
    lim_m[2] = BYTE_W'(LIM_TEMP3_RST);
    lim_m[3] = BYTE_W'(LIM_TEMP4_RST);
    lim_m[4] = BYTE_W'(LIM_UMIDADE_RST);
    repeat (16) @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);
    check_bit("reset erro_config", 1'b0, erro_config);
    check_bit("reset pslverr", 1'b0, pslverr);
    check_bit("reset nivel_valid", 1'b0, nivel_valid);
    check_bit("reset erro_medida", 1'b0, erro_medida);
    check_bit("reset fan", 1'b0, pwm_ventoinha);

    read_all("reset");
    apb_write(REG_LIM_TEMP1, 8'd15, "write temp1");
    apb_write(REG_LIM_TEMP2, 8'd22, "write temp2");
    apb_write(REG_LIM_TEMP3, 8'd28, "write temp3");
    apb_write(REG_LIM_TEMP4, 8'd40, "write temp4");
    apb_write(REG_LIM_UMIDADE, 8'd60, "write umidade");
    read_all("ordered");

    // Order violations, equal neighbours included.
    apb_write(REG_LIM_TEMP2, 8'd10, "bad temp2");
    apb_read(REG_LIM_TEMP2, "after bad temp2");
    apb_write(REG_LIM_TEMP3, 8'd45, "bad temp3");
    apb_read(REG_LIM_TEMP3, "after bad temp3");
    apb_write(REG_LIM_TEMP1, 8'd22, "bad temp1");
    apb_read(REG_LIM_TEMP1, "after bad temp1");
    apb_write(REG_LIM_TEMP4, 8'd28, "bad temp4");
    apb_read(REG_LIM_TEMP4, "after bad temp4");
    apb_write(5'h14, 8'd5, "unmapped write");
    apb_read(5'h02, "unmapped read");
    apb_write(REG_LIM_TEMP4, 8'd42, "recover temp4");
    read_all("recovered");

    for (int i = 0; i < 150; i++) begin
      drive_frame(BYTE_W'({$random(seed)} % 100), BYTE_W'({$random(seed)} % 50), 1'b0);
      gap = {$random(seed)} % 3; // Zero gives back to back.
      idle_cycles(gap);
    end
    wait_drain();

    for (int i = 0; i < 30; i++) begin
      corrupt = ({$random(seed)} % 2) == 1;
      drive_frame(BYTE_W'({$random(seed)} % 100), BYTE_W'({$random(seed)} % 50), corrupt);
      gap = {$random(seed)} % 3;
      idle_cycles(gap);
    end
    wait_drain();

    // Humidity around the limit.
    for (int d = 1; d >= -1; d--) begin
      drive_frame(lim_m[4] + BYTE_W'(d), 8'd30, 1'b0);
      wait_drain();
      check_bit($sformatf("rele humidity limit offset %0d", d),
                ref_rele(lim_m[4] + BYTE_W'(d)), rele);
    end

    for (int lvl = 0; lvl < 5; lvl++) begin
      temp = (lvl == 0) ? lim_m[0] - 8'd1 : lim_m[lvl-1];
      drive_frame(8'd0, temp, 1'b0);
      wait_drain();
      repeat (SERVO_PERIOD + 2) @(negedge clock); // Both periods restarted.
      fan_high   = 0;
      servo_high = 0;
      for (int i = 0; i < SERVO_PERIOD; i++) begin
        @(negedge clock);
        if (i < PWM_PERIOD && pwm_ventoinha)
          fan_high++;
        if (pwm_servo)
          servo_high++;
      end
      check_count($sformatf("fan high level %0d", lvl), ref_fan_high(lvl), fan_high);
      check_count($sformatf("servo high level %0d", lvl), ref_servo_high(lvl), servo_high);
    end

    if (err_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      fail_run("Checks reported errors during the run");
    end
  end

endmodule

//--- tb.f
rtl/tusca_pkg.sv
rtl/tusca_regs_pkg.sv
rtl/tusca_config_regs.sv
rtl/tusca_frame_check.sv
rtl/tusca_level_classifier.sv
rtl/tusca_actuator.sv
rtl/tusca.sv
sim/tb_clock.sv
sim/tusca_tb.sv
